//--- filelist.f
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_reg_file.sv
execute/rv_alu.sv
execute/rv_lsu.sv
execute/rv_commit.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - common/rv_isa_pkg.sv
  - common/rv_core_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_reg_file.sv
  - execute/rv_alu.sv
  - execute/rv_lsu.sv
  - execute/rv_commit.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - sim/tb_rv_core.sv

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*, rv_isa_pkg::*; ();

  localparam word_t NOP          = 32'h0000_0013; // addi x0, x0, 0
  localparam int    RANDOM_STEPS = 400;
  localparam int    MAX_STEPS    = 600;

  logic  clk;
  logic  rst;
  word_t pc_to_imem;
  word_t insn_from_imem;
  word_t addr_to_dmem;
  word_t load_data_from_dmem;
  word_t store_data_to_dmem;
  strb_t store_we_to_dmem;
  logic  halt;

  // reference model state
  integer seed = 32'ha0c4_eae0;
  word_t  m_regs [32];
  word_t  m_pc;
  word_t  imem [word_t];  // program, filled as the model reaches it
  word_t  dmem [word_t];  // sparse, word addressed
  int     executed;
  int     sweep_idx;
  logic   saw_halt;

  // what the current instruction should do
  word_t     e_addr, e_sdata, e_next_pc, e_wval;
  strb_t     e_strb;
  logic      e_halt, e_mem, e_we;
  reg_addr_t e_rd;

  rv_core dut0 (
    .clk                 (clk),
    .rst                 (rst),
    .pc_to_imem          (pc_to_imem),
    .insn_from_imem      (insn_from_imem),
    .addr_to_dmem        (addr_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .halt                (halt)
  );

  always #4 clk = ~clk;

  function automatic int rnd();
    return $random(seed);
  endfunction

  function automatic word_t enc_r(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                  reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(int imm, reg_addr_t rs1, funct3_t f3, reg_addr_t rd,
                                  opcode_t op);
    word_t w;
    w = imm;
    return {w[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(int imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
    word_t w;
    w = imm;
    return {w[11:5], rs2, rs1, f3, w[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(int imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
    word_t w;
    w = imm;
    return {w[12], w[10:5], rs2, rs1, f3, w[4:1], w[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_j(int imm, reg_addr_t rd);
    word_t w;
    w = imm;
    return {w[20], w[10:1], w[11], w[19:12], rd, OP_JAL};
  endfunction

  // unwritten words read back a pattern of their own address
  function automatic word_t dmem_read(word_t a);
    if (dmem.exists(a)) return dmem[a];
    return a ^ {a[15:0], a[31:16]} ^ 32'h6b8f_21d3;
  endfunction

  // next instruction of the program, built from the model state
  function automatic word_t gen_insn();
    int        kind, imm, start;
    reg_addr_t rs1, rs2, rd;
    funct3_t   f3;
    word_t     target, diff;
    if (executed >= RANDOM_STEPS) begin
      if (sweep_idx < 32) begin // store every register, x0 too
        sweep_idx++;
        return enc_s(1024 + 4 * (sweep_idx - 1), reg_addr_t'(sweep_idx - 1), 5'd0, F3_W);
      end
      return INSN_ECALL;
    end
    kind = rnd() & 15;
    rs1  = reg_addr_t'(rnd());
    rs2  = reg_addr_t'(rnd());
    rd   = reg_addr_t'(rnd());
    f3   = funct3_t'(rnd());
    imm  = (rnd() & 4095) - 2048;
    case (kind)
      0, 1, 2, 3: begin
        if ((f3 == F3_ADD || f3 == F3_SR) && (rnd() & 1)) begin
          return enc_r(FUNCT7_ALT, rs2, rs1, f3, rd);
        end
        return enc_r(7'b0, rs2, rs1, f3, rd);
      end
      4, 5, 6: begin
        if (f3 == F3_SLL) imm = imm & 31;
        else if (f3 == F3_SR) imm = (imm & 31) | ((rnd() & 1) ? 32'h400 : 0); // srai
        return enc_i(imm, rs1, f3, rd, OP_IMM);
      end
      7: begin
        target = rnd(); // upper immediate bits
        return {target[31:12], rd, (rnd() & 1) ? OP_LUI : OP_AUIPC};
      end
      8, 9, 10, 11: begin
        if (rnd() & 1) begin
          rs1 = '0; // small window so loads see earlier stores
          imm = rnd() & 255;
        end else begin
          imm = (rnd() & 2047) - 1024;
        end
        if (kind < 10) f3 = funct3_t'(f3 % 3);
        else if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = F3_W;
        target = m_regs[rs1] + word_t'(imm);
        if (f3[1:0] == 2'b01) imm = imm - int'(target[0]);
        else if (f3[1:0] == 2'b10) imm = imm - int'(target[1:0]);
        if (kind < 10) return enc_s(imm, rs2, rs1, f3);
        return enc_i(imm, rs1, f3, rd, OP_LOAD);
      end
      12, 13: begin
        if (f3 == 3'b010 || f3 == 3'b011) f3 = F3_BEQ;
        if ((rnd() & 3) == 0) rs2 = rs1; // equal operands now and then
        return enc_b(4 * (1 + (rnd() & 15)), rs2, rs1, f3);
      end
      14: return enc_j(4 * (1 + (rnd() & 15)), rd);
      default: begin
        // jalr forward, through any register close enough to the target
        target = m_pc + 4 * (1 + (rnd() & 15));
        start  = rnd() & 31;
        for (int i = 0; i < 32; i++) begin
          diff = target - m_regs[(start + i) & 31];
          if ($signed(diff) >= -2048 && $signed(diff) <= 2046) begin
            return enc_i(int'($signed(diff)) + (rnd() & 1), reg_addr_t'(start + i), F3_ADD, rd,
                         OP_JALR);
          end
        end
        return enc_i(imm, rs1, F3_ADD, rd, OP_IMM);
      end
    endcase
  endfunction

  function automatic word_t alu_model(funct3_t f3, logic alt, word_t x, word_t y);
    case (f3)
      F3_ADD:  return alt ? x - y : x + y;
      F3_SLL:  return x << y[4:0];
      F3_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      F3_SLTU: return (x < y) ? 32'd1 : 32'd0;
      F3_XOR:  return x ^ y;
      F3_SR:   return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      F3_OR:   return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(funct3_t f3, word_t x, word_t y);
    case (f3)
      F3_BEQ:  return x == y;
      F3_BNE:  return x != y;
      F3_BLT:  return $signed(x) < $signed(y);
      F3_BGE:  return $signed(x) >= $signed(y);
      F3_BLTU: return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic predict(input word_t insn);
    opcode_t op;
    funct3_t f3;
    word_t   a, b, imm_i, imm_s, imm_b, imm_j, ea, lw;
    op    = insn[6:0];
    f3    = insn[14:12];
    a     = m_regs[insn[19:15]];
    b     = m_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    e_rd      = insn[11:7];
    e_we      = 1'b0;
    e_wval    = '0;
    e_mem     = 1'b0;
    e_strb    = '0;
    e_sdata   = '0;
    e_halt    = (insn == INSN_ECALL);
    e_next_pc = m_pc + 4;
    ea        = a + ((op == OP_STORE) ? imm_s : imm_i);
    e_addr    = {ea[31:2], 2'b00};
    case (op)
      OP_REG, OP_IMM: begin
        e_we   = 1'b1;
        e_wval = alu_model(f3, insn[30] && (op == OP_REG || f3 == F3_SR), a,
                           (op == OP_REG) ? b : imm_i);
      end
      OP_LUI: begin
        e_we   = 1'b1;
        e_wval = {insn[31:12], 12'b0};
      end
      OP_AUIPC: begin
        e_we   = 1'b1;
        e_wval = m_pc + {insn[31:12], 12'b0};
      end
      OP_JAL: begin
        e_we      = 1'b1;
        e_wval    = m_pc + 4;
        e_next_pc = m_pc + imm_j;
      end
      OP_JALR: begin
        e_we      = 1'b1;
        e_wval    = m_pc + 4;
        e_next_pc = (a + imm_i) & ~32'h1;
      end
      OP_BRANCH: if (branch_taken(f3, a, b)) e_next_pc = m_pc + imm_b;
      OP_LOAD: begin
        e_mem = 1'b1;
        e_we  = 1'b1;
        lw    = dmem_read(e_addr) >> {ea[1:0], 3'b000};
        case (f3)
          F3_B:    e_wval = {{24{lw[7]}}, lw[7:0]};
          F3_H:    e_wval = {{16{lw[15]}}, lw[15:0]};
          F3_BU:   e_wval = {24'b0, lw[7:0]};
          F3_HU:   e_wval = {16'b0, lw[15:0]};
          default: e_wval = lw;
        endcase
      end
      OP_STORE: begin
        e_mem   = 1'b1;
        e_sdata = b << {ea[1:0], 3'b000};
        if (f3 == F3_B) e_strb = 4'b0001 << ea[1:0];
        else if (f3 == F3_H) e_strb = 4'b0011 << ea[1:0];
        else e_strb = 4'b1111;
      end
      default: ;
    endcase
  endtask

  task automatic commit_model();
    word_t w;
    if (e_we && e_rd != '0) m_regs[e_rd] = e_wval;
    if (e_strb != '0) begin
      w = dmem_read(e_addr);
      for (int i = 0; i < 4; i++) begin
        if (e_strb[i]) w[8*i +: 8] = e_sdata[8*i +: 8];
      end
      dmem[e_addr] = w;
    end
    m_pc = e_next_pc;
    executed++;
  endtask

  // fetch at the model pc and present the matching load word
  task automatic issue_next();
    word_t insn;
    if (!imem.exists(m_pc)) imem[m_pc] = gen_insn();
    insn = imem[m_pc];
    predict(insn);
    insn_from_imem      <= insn;
    load_data_from_dmem <= dmem_read(e_addr);
  endtask

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h (step %0d)", name, exp, act, executed);
      abort_run();
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b (step %0d)", name, exp, act, executed);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b (step %0d)", name, exp, act, executed);
      abort_run();
    end
  endtask

  task automatic check_outputs();
    word_t mask;
    check_word("pc", m_pc, pc_to_imem);
    check_flag("halt", e_halt, halt);
    check_strb("store strobe", e_strb, store_we_to_dmem);
    if (e_mem) check_word("dmem address", e_addr, addr_to_dmem);
    if (e_strb != '0) begin
      mask = {{8{e_strb[3]}}, {8{e_strb[2]}}, {8{e_strb[1]}}, {8{e_strb[0]}}};
      check_word("store data", e_sdata & mask, store_data_to_dmem & mask);
    end
  endtask

  initial begin
    clk                 = 1'b0;
    rst                 = 1'b1;
    insn_from_imem      = NOP;
    load_data_from_dmem = '0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc      = '0;
    executed  = 0;
    sweep_idx = 0;
    saw_halt  = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_word("reset pc", 32'h0, pc_to_imem);
      check_strb("reset strobe", 4'b0000, store_we_to_dmem);
      check_flag("reset halt", 1'b0, halt);
      @(posedge clk);
    end
    rst <= 1'b0;
    issue_next();
    for (int steps = 0; steps < MAX_STEPS && !saw_halt; steps++) begin
      @(negedge clk);
      check_outputs();
      if (e_halt) begin
        saw_halt = 1'b1;
      end else begin
        @(posedge clk);
        commit_model();
        issue_next();
      end
    end
    if (saw_halt) begin
      for (int i = 0; i < 4; i++) begin // ecall stays on the bus
        @(posedge clk);
        @(negedge clk);
        check_word("halted pc", m_pc, pc_to_imem);
        check_flag("halt level", 1'b1, halt);
        check_strb("halted strobe", 4'b0000, store_we_to_dmem);
      end
    end
    if (!saw_halt) begin
      $display("program did not reach ecall within %0d steps", MAX_STEPS);
      abort_run();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*, rv_isa_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output word_t pc_to_imem,
  input  word_t insn_from_imem,
  output word_t addr_to_dmem,
  input  word_t load_data_from_dmem,
  output word_t store_data_to_dmem,
  output strb_t store_we_to_dmem,
  output logic  halt
);

  reg_addr_t rs1, rs2, rd;
  word_t     imm;
  alu_op_t   alu_op;
  logic      use_imm;
  funct3_t   funct3;
  logic      reg_we;
  logic      is_load, is_store, is_branch;
  wb_sel_t   wb_sel;
  pc_sel_t   pc_sel;
  word_t     rs1_data, rs2_data;
  word_t     alu_a;
  word_t     alu_result;
  logic      take_branch;
  word_t     load_result;
  word_t     rd_data;
  word_t     pc;

  assign pc_to_imem = pc;
  assign alu_a      = (wb_sel == WB_UPPER) ? pc : rs1_data; // auipc

  rv_decoder u_decoder (
    .insn      (insn_from_imem),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .funct3    (funct3),
    .reg_we    (reg_we),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_branch (is_branch),
    .wb_sel    (wb_sel),
    .pc_sel    (pc_sel),
    .halt      (halt)
  );

  rv_reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .rs1_data    (alu_a),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .use_imm     (use_imm),
    .is_branch   (is_branch),
    .alu_op      (alu_op),
    .funct3      (funct3),
    .alu_result  (alu_result),
    .take_branch (take_branch)
  );

  rv_lsu u_lsu (
    .rs1_data            (rs1_data),
    .rs2_data            (rs2_data),
    .imm                 (imm),
    .funct3              (funct3),
    .is_load             (is_load),
    .is_store            (is_store),
    .load_data_from_dmem (load_data_from_dmem),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .load_result         (load_result)
  );

  rv_commit u_commit (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .take_branch (take_branch),
    .pc_sel      (pc_sel),
    .wb_sel      (wb_sel),
    .imm         (imm),
    .alu_result  (alu_result),
    .load_result (load_result),
    .pc          (pc),
    .rd_data     (rd_data)
  );

endmodule

//--- execute/rv_commit.sv
`timescale 1ns/1ps

module rv_commit import rv_core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    halt,
  input  logic    take_branch,
  input  pc_sel_t pc_sel,
  input  wb_sel_t wb_sel,
  input  word_t   imm,
  input  word_t   alu_result,
  input  word_t   load_result,
  output word_t   pc,
  output word_t   rd_data
);

  word_t pc_plus4;
  word_t pc_target; // branch and jal
  word_t next_pc;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (pc_sel)
      PC_BRANCH: next_pc = take_branch ? pc_target : pc_plus4;
      PC_JAL:    next_pc = pc_target;
      PC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!halt) begin // ecall parks the core
      pc <= next_pc;
    end
  end

  // auipc lands here too, pc + upper immediate from the adder
  always_comb begin
    case (wb_sel)
      WB_LOAD: rd_data = load_result;
      WB_PC4:  rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- execute/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu import rv_core_pkg::*, rv_isa_pkg::*; (
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   imm,
  input  funct3_t funct3,
  input  logic    is_load,
  input  logic    is_store,
  input  word_t   load_data_from_dmem,
  output word_t   addr_to_dmem,
  output word_t   store_data_to_dmem,
  output strb_t   store_we_to_dmem,
  output word_t   load_result
);

  word_t      eff_addr;
  logic [1:0] offset;     // byte within the word
  word_t      load_shifted;

  assign eff_addr     = rs1_data + imm;
  assign offset       = eff_addr[1:0];
  assign addr_to_dmem = {eff_addr[31:2], 2'b00};

  // store lanes
  assign store_data_to_dmem = rs2_data << {offset, 3'b000};

  always_comb begin
    store_we_to_dmem = '0;
    if (is_store) begin
      case (funct3)
        F3_B:    store_we_to_dmem = strb_t'(4'b0001) << offset;
        F3_H:    store_we_to_dmem = strb_t'(4'b0011) << offset;
        F3_W:    store_we_to_dmem = 4'b1111;
        default: store_we_to_dmem = '0;
      endcase
    end
  end

  // load lanes, brought down to bit 0 then extended
  assign load_shifted = load_data_from_dmem >> {offset, 3'b000};

  always_comb begin
    load_result = '0;
    if (is_load) begin
      case (funct3)
        F3_B:    load_result = {{24{load_shifted[7]}}, load_shifted[7:0]};
        F3_H:    load_result = {{16{load_shifted[15]}}, load_shifted[15:0]};
        F3_W:    load_result = load_shifted;
        F3_BU:   load_result = {24'b0, load_shifted[7:0]};
        F3_HU:   load_result = {16'b0, load_shifted[15:0]};
        default: load_result = '0;
      endcase
    end
  end

endmodule

//--- execute/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*, rv_isa_pkg::*; (
  input  word_t   rs1_data, // pc for auipc
  input  word_t   rs2_data,
  input  word_t   imm,
  input  logic    use_imm,
  input  logic    is_branch,
  input  alu_op_t alu_op,
  input  funct3_t funct3,
  output word_t   alu_result,
  output logic    take_branch
);

  word_t      op_b;
  logic [4:0] shamt;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = rs1_data + op_b;
      ALU_SUB:  alu_result = rs1_data - op_b;
      ALU_SLL:  alu_result = rs1_data << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, rs1_data < op_b};
      ALU_XOR:  alu_result = rs1_data ^ op_b;
      ALU_SRL:  alu_result = rs1_data >> shamt;
      ALU_SRA:  alu_result = $signed(rs1_data) >>> shamt;
      ALU_OR:   alu_result = rs1_data | op_b;
      ALU_AND:  alu_result = rs1_data & op_b;
      default:  alu_result = '0;
    endcase
  end

  // branch compare always on the two registers
  always_comb begin
    take_branch = 1'b0;
    if (is_branch) begin
      case (funct3)
        F3_BEQ:  take_branch = (rs1_data == rs2_data);
        F3_BNE:  take_branch = (rs1_data != rs2_data);
        F3_BLT:  take_branch = ($signed(rs1_data) < $signed(rs2_data));
        F3_BGE:  take_branch = ($signed(rs1_data) >= $signed(rs2_data));
        F3_BLTU: take_branch = (rs1_data < rs2_data);
        F3_BGEU: take_branch = (rs1_data >= rs2_data);
        default: take_branch = 1'b0; // 010, 011 reserved
      endcase
    end
  end

endmodule

//--- verilog/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     rd_data,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [NUM_REGS];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin // x0 is never written
      regs[rd] <= rd_data;
    end
  end

  // a write never lands an unknown value or index
  a_write_known: assert property (@(posedge clk) disable iff (rst)
    we |-> !$isunknown({rd, rd_data}));

endmodule

//--- verilog/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*, rv_isa_pkg::*; (
  input  word_t     insn,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_op_t   alu_op,
  output logic      use_imm,
  output funct3_t   funct3,
  output logic      reg_we,
  output logic      is_load,
  output logic      is_store,
  output logic      is_branch,
  output wb_sel_t   wb_sel,
  output pc_sel_t   pc_sel,
  output logic      halt
);

  opcode_t opcode;
  funct7_t funct7;
  word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t alu_fn;

  assign opcode = insn[6:0];
  assign funct7 = insn[31:25];
  assign funct3 = insn[14:12];
  assign rd     = insn[11:7];
  assign rs2    = insn[24:20];
  assign rs1    = (opcode == OP_LUI) ? '0 : insn[19:15]; // lui adds its immediate to x0

  assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign halt = (insn == INSN_ECALL);

  // alu function for OP_REG and OP_IMM
  always_comb begin
    case (funct3)
      F3_ADD:  alu_fn = (opcode == OP_REG && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_fn = ALU_SLL;
      F3_SLT:  alu_fn = ALU_SLT;
      F3_SLTU: alu_fn = ALU_SLTU;
      F3_XOR:  alu_fn = ALU_XOR;
      F3_SR:   alu_fn = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_fn = ALU_OR;
      default: alu_fn = ALU_AND;
    endcase
  end

  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    wb_sel    = WB_ALU;
    pc_sel    = PC_SEQ;
    case (opcode)
      OP_REG: begin
        alu_op = alu_fn;
        reg_we = 1'b1;
      end
      OP_IMM: begin
        alu_op  = alu_fn;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      OP_LOAD: begin
        use_imm = 1'b1;
        reg_we  = 1'b1;
        is_load = 1'b1;
        wb_sel  = WB_LOAD;
      end
      OP_STORE: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = 1'b1;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        pc_sel    = PC_BRANCH;
      end
      OP_JAL: begin
        imm    = imm_j;
        reg_we = 1'b1;
        wb_sel = WB_PC4;
        pc_sel = PC_JAL;
      end
      OP_JALR: begin
        use_imm = 1'b1; // target computed by the alu adder
        reg_we  = 1'b1;
        wb_sel  = WB_PC4;
        pc_sel  = PC_JALR;
      end
      OP_LUI: begin
        imm     = imm_u;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      OP_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        reg_we  = 1'b1;
        wb_sel  = WB_UPPER;
      end
      OP_SYSTEM: reg_we = 1'b0; // ecall writes nothing
      default: ;
    endcase
  end

endmodule

//--- common/rv_core_pkg.sv
package rv_core_pkg;

  localparam int NUM_REGS = 32;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  strb_t;     // one bit per byte lane

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // register write source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4,
    WB_UPPER  // auipc only, pc fed to alu operand a
  } wb_sel_t;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_sel_t;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN     = 32;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  typedef logic [OPCODE_W-1:0] opcode_t;
  typedef logic [FUNCT3_W-1:0] funct3_t;
  typedef logic [FUNCT7_W-1:0] funct7_t;

  // major opcodes
  localparam opcode_t OP_LOAD   = 7'b00_000_11;
  localparam opcode_t OP_STORE  = 7'b01_000_11;
  localparam opcode_t OP_BRANCH = 7'b11_000_11;
  localparam opcode_t OP_JALR   = 7'b11_001_11;
  localparam opcode_t OP_JAL    = 7'b11_011_11;
  localparam opcode_t OP_IMM    = 7'b00_100_11;
  localparam opcode_t OP_REG    = 7'b01_100_11;
  localparam opcode_t OP_SYSTEM = 7'b11_100_11;
  localparam opcode_t OP_AUIPC  = 7'b00_101_11;
  localparam opcode_t OP_LUI    = 7'b01_101_11;

  // branch kinds
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // load and store sizes
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // alu functions, OP_REG and OP_IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct7_t FUNCT7_ALT = 7'b0100000; // sub, sra, srai

  localparam logic [XLEN-1:0] INSN_ECALL = 32'h0000_0073;

endpackage
